//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_perip_bridge_axi
FILELIST    ?= sim.f
BUILD_DIR   ?= obj_dir
JOBS        ?= 4
EXTRA_FLAGS ?=

VL_FLAGS := --binary --timing --assert --timescale 1ns/100ps -j $(JOBS)
PASS_MSG := Simulation PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove $(BUILD_DIR)"
	@echo "make help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS EXTRA_FLAGS"

test:
	$(VERILATOR) $(VL_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
	    echo "test: pass"; \
	else \
	    echo "test: fail"; \
	    exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/axi_burst_addr.sv
`include "perip_axi_cfg.svh"

module axi_burst_addr (
    input  perip_axi_pkg::addr_t  cur_addr,
    input  perip_axi_pkg::len_t   len,
    input  perip_axi_pkg::burst_t burst,
    output perip_axi_pkg::addr_t  next_addr
);
    import perip_axi_pkg::*;

    localparam int WORD_W = `PERIP_ADDR_W - `PERIP_ADDR_LSB;

    logic [WORD_W-1:0] cur_word;
    logic [WORD_W-1:0] inc_word;
    logic [WORD_W-1:0] wrap_mask;   // len+1 is a power of two for WRAP
    logic [WORD_W-1:0] wrap_word;

    assign cur_word  = cur_addr[`PERIP_ADDR_W-1:`PERIP_ADDR_LSB];
    assign inc_word  = cur_word + 1'b1;
    assign wrap_mask = WORD_W'(len);

    // keep the window base, let only the low bits roll over
    assign wrap_word = (cur_word & ~wrap_mask) | (inc_word & wrap_mask);

    always_comb begin
        case (burst)
            BURST_FIXED: next_addr = cur_addr;
            BURST_WRAP: begin
                next_addr = {wrap_word, {`PERIP_ADDR_LSB{1'b0}}};
            end
            default: begin  // INCR and reserved
                next_addr = {inc_word, {`PERIP_ADDR_LSB{1'b0}}};
            end
        endcase
    end

endmodule

//--- rtl/axi_read_engine.sv
`include "perip_axi_cfg.svh"

module axi_read_engine (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    // AR channel
    input  perip_axi_pkg::id_t        ar_id,
    input  perip_axi_pkg::burst_cmd_t ar_cmd,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    // R channel
    output perip_axi_pkg::id_t        r_id,
    output perip_axi_pkg::data_t      r_data,
    output logic                      r_last,
    output logic                      r_valid,
    input  logic                      r_ready,
    // register bus
    output perip_axi_pkg::bus_req_t   rd_req,
    output logic                      rd_req_valid,
    input  logic                      rd_grant,
    input  perip_axi_pkg::data_t      bus_rdata
);
    import perip_axi_pkg::*;

    rd_state_t  state;
    burst_cmd_t cmd;          // addr follows the current beat
    len_t       beat_cnt;
    id_t        id_q;
    logic       data_fresh;   // bus_rdata arrived this cycle
    data_t      data_q;
    addr_t      next_addr;

    axi_burst_addr i_next_addr (
        .cur_addr (cmd.addr),
        .len      (cmd.len),
        .burst    (cmd.burst),
        .next_addr(next_addr)
    );

    assign ar_ready     = (state == RD_IDLE);
    assign rd_req_valid = (state == RD_REQ);
    assign rd_req       = '{addr: cmd.addr, write: 1'b0, wdata: '0, strb: '0};

    assign r_valid = (state == RD_DATA);
    assign r_id    = id_q;
    assign r_last  = (beat_cnt == cmd.len);
    assign r_data  = data_fresh ? bus_rdata : data_q;  // held copy under back-pressure

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= RD_IDLE;
            beat_cnt   <= '0;
            data_fresh <= 1'b0;
        end else begin
            data_fresh <= rd_req_valid && rd_grant;
            case (state)
                RD_IDLE: begin
                    if (ar_valid) begin
                        state    <= RD_REQ;
                        beat_cnt <= '0;
                    end
                end
                RD_REQ: begin
                    if (rd_grant)
                        state <= RD_DATA;   // word lands in bus_rdata
                end
                RD_DATA: begin
                    if (r_ready) begin
                        if (r_last) begin
                            state <= RD_IDLE;
                        end else begin
                            state    <= RD_REQ;
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_valid && ar_ready) begin
            cmd  <= ar_cmd;
            id_q <= ar_id;
        end else if (r_valid && r_ready && !r_last) begin
            cmd.addr <= next_addr;
        end
        if (data_fresh)
            data_q <= bus_rdata;
    end

    // beat is held stable while the master stalls
    a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_last));

endmodule

//--- rtl/axi_write_engine.sv
`include "perip_axi_cfg.svh"

module axi_write_engine (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    // AW channel
    input  perip_axi_pkg::id_t        aw_id,
    input  perip_axi_pkg::burst_cmd_t aw_cmd,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    // W channel
    input  perip_axi_pkg::data_t      w_data,
    input  perip_axi_pkg::strb_t      w_strb,
    input  logic                      w_last,
    input  logic                      w_valid,
    output logic                      w_ready,
    // B channel
    output perip_axi_pkg::id_t        b_id,
    output logic                      b_valid,
    input  logic                      b_ready,
    // register bus
    output perip_axi_pkg::bus_req_t   wr_req,
    output logic                      wr_req_valid,
    input  logic                      wr_grant
);
    import perip_axi_pkg::*;

    wr_state_t  state;
    burst_cmd_t cmd;        // addr follows the current beat
    id_t        id_q;
    addr_t      next_addr;
    logic       w_beat;

    axi_burst_addr i_next_addr (
        .cur_addr (cmd.addr),
        .len      (cmd.len),
        .burst    (cmd.burst),
        .next_addr(next_addr)
    );

    assign aw_ready = (state == WR_IDLE);

    // a W beat goes straight onto the bus, so it only completes when granted
    assign wr_req_valid = (state == WR_DATA) && w_valid;
    assign wr_req = '{addr: cmd.addr, write: 1'b1, wdata: w_data, strb: w_strb};
    assign w_ready = wr_grant;
    assign w_beat  = w_valid && w_ready;

    assign b_valid = (state == WR_RESP);
    assign b_id    = id_q;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_valid)
                        state <= WR_DATA;
                end
                WR_DATA: begin
                    // WLAST closes the burst, no beat count kept
                    if (w_beat && w_last)
                        state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_ready)
                        state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_valid && aw_ready) begin
            cmd  <= aw_cmd;
            id_q <= aw_id;
        end else if (w_beat) begin
            cmd.addr <= next_addr;    // address of the following beat
        end
    end

    // a response only follows the closing W beat
    a_b_after_wlast: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(b_valid) |-> $past(w_valid && w_ready && w_last));

endmodule

//--- rtl/perip_axi_cfg.svh
`ifndef PERIP_AXI_CFG_SVH
`define PERIP_AXI_CFG_SVH

// bus widths
`define PERIP_ADDR_W 16
`define PERIP_DATA_W 32
`define PERIP_ID_W 4
`define PERIP_LEN_W 8       // AxLEN, beats minus one
`define PERIP_ADDR_LSB 2    // byte address to word index

// one burst per engine, no queues, so AxLEN is the only burst limit

// word indices in the register window
`define PERIP_IDX_SW_LO 0
`define PERIP_IDX_SW_HI 1
`define PERIP_IDX_KEY 2
`define PERIP_IDX_SEG_LO 4
`define PERIP_IDX_SEG_HI 5  // only [7:0] exists
`define PERIP_IDX_LED 6

`endif

//--- rtl/perip_axi_pkg.sv
`include "perip_axi_cfg.svh"

package perip_axi_pkg;

    typedef logic [`PERIP_ADDR_W-1:0] addr_t;
    typedef logic [`PERIP_DATA_W-1:0] data_t;
    typedef logic [`PERIP_DATA_W/8-1:0] strb_t;
    typedef logic [`PERIP_ID_W-1:0] id_t;
    typedef logic [`PERIP_LEN_W-1:0] len_t;

    // AxBURST encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11   // handled as INCR
    } burst_t;

    // what an engine keeps from an accepted AW or AR beat
    typedef struct packed {
        addr_t  addr;
        len_t   len;
        burst_t burst;
    } burst_cmd_t;

    // one access on the register bus
    typedef struct packed {
        addr_t addr;      // word aligned byte address
        logic  write;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_DATA} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

endpackage

//--- rtl/perip_bridge_axi.sv
module perip_bridge_axi (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    // write address
    input  perip_axi_pkg::id_t     S_AXI_AWID,
    input  perip_axi_pkg::addr_t   S_AXI_AWADDR,
    input  perip_axi_pkg::len_t    S_AXI_AWLEN,
    input  logic [1:0]             S_AXI_AWBURST,
    input  logic                   S_AXI_AWVALID,
    output logic                   S_AXI_AWREADY,
    // write data
    input  perip_axi_pkg::data_t   S_AXI_WDATA,
    input  perip_axi_pkg::strb_t   S_AXI_WSTRB,
    input  logic                   S_AXI_WLAST,
    input  logic                   S_AXI_WVALID,
    output logic                   S_AXI_WREADY,
    // write response
    output perip_axi_pkg::id_t     S_AXI_BID,
    output logic [1:0]             S_AXI_BRESP,
    output logic                   S_AXI_BVALID,
    input  logic                   S_AXI_BREADY,
    // read address
    input  perip_axi_pkg::id_t     S_AXI_ARID,
    input  perip_axi_pkg::addr_t   S_AXI_ARADDR,
    input  perip_axi_pkg::len_t    S_AXI_ARLEN,
    input  logic [1:0]             S_AXI_ARBURST,
    input  logic                   S_AXI_ARVALID,
    output logic                   S_AXI_ARREADY,
    // read data
    output perip_axi_pkg::id_t     S_AXI_RID,
    output perip_axi_pkg::data_t   S_AXI_RDATA,
    output logic [1:0]             S_AXI_RRESP,
    output logic                   S_AXI_RLAST,
    output logic                   S_AXI_RVALID,
    input  logic                   S_AXI_RREADY,
    // board peripherals
    input  logic [63:0]            virtual_sw_input,
    input  logic [7:0]             virtual_key_input,
    output logic [39:0]            virtual_seg_output,
    output logic [31:0]            virtual_led_output
);
    import perip_axi_pkg::*;

    burst_cmd_t aw_cmd;
    burst_cmd_t ar_cmd;
    bus_req_t   rd_req;
    bus_req_t   wr_req;
    bus_req_t   bus_req;
    logic       rd_req_valid;
    logic       wr_req_valid;
    logic       rd_grant;
    logic       wr_grant;
    logic       bus_valid;
    data_t      bus_rdata;

    assign aw_cmd = '{addr: S_AXI_AWADDR, len: S_AXI_AWLEN, burst: burst_t'(S_AXI_AWBURST)};
    assign ar_cmd = '{addr: S_AXI_ARADDR, len: S_AXI_ARLEN, burst: burst_t'(S_AXI_ARBURST)};
    assign S_AXI_RRESP = 2'b00;     // OKAY
    assign S_AXI_BRESP = 2'b00;

    axi_read_engine i_rd_engine (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .ar_id(S_AXI_ARID), .ar_cmd(ar_cmd), .ar_valid(S_AXI_ARVALID), .ar_ready(S_AXI_ARREADY),
        .r_id(S_AXI_RID), .r_data(S_AXI_RDATA), .r_last(S_AXI_RLAST),
        .r_valid(S_AXI_RVALID), .r_ready(S_AXI_RREADY),
        .rd_req, .rd_req_valid, .rd_grant, .bus_rdata
    );

    axi_write_engine i_wr_engine (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .aw_id(S_AXI_AWID), .aw_cmd(aw_cmd), .aw_valid(S_AXI_AWVALID), .aw_ready(S_AXI_AWREADY),
        .w_data(S_AXI_WDATA), .w_strb(S_AXI_WSTRB), .w_last(S_AXI_WLAST),
        .w_valid(S_AXI_WVALID), .w_ready(S_AXI_WREADY),
        .b_id(S_AXI_BID), .b_valid(S_AXI_BVALID), .b_ready(S_AXI_BREADY),
        .wr_req, .wr_req_valid, .wr_grant
    );

    perip_bus_arbiter i_arbiter (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .rd_req, .rd_req_valid, .wr_req, .wr_req_valid,
        .rd_grant, .wr_grant, .bus_req, .bus_valid
    );

    perip_regs i_regs (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .bus_req, .bus_valid, .bus_rdata,
        .virtual_sw_input, .virtual_key_input,
        .virtual_seg_output, .virtual_led_output
    );

endmodule

//--- rtl/perip_bus_arbiter.sv
`include "perip_axi_cfg.svh"

module perip_bus_arbiter (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  perip_axi_pkg::bus_req_t rd_req,
    input  logic                    rd_req_valid,
    input  perip_axi_pkg::bus_req_t wr_req,
    input  logic                    wr_req_valid,
    output logic                    rd_grant,
    output logic                    wr_grant,
    output perip_axi_pkg::bus_req_t bus_req,
    output logic                    bus_valid
);
    import perip_axi_pkg::*;

    logic last_wr;  // write engine won the last grant

    // on contention the engine that was not served last wins
    assign rd_grant  = rd_req_valid && (!wr_req_valid || last_wr);
    assign wr_grant  = wr_req_valid && (!rd_req_valid || !last_wr);
    assign bus_valid = rd_grant || wr_grant;
    assign bus_req   = wr_grant ? wr_req : rd_req;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN)
            last_wr <= 1'b1;    // read goes first after reset
        else if (bus_valid)
            last_wr <= wr_grant;
    end

    a_grant_excl: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(rd_grant && wr_grant));

    // requests stay up until served, so a loser is served on the next cycle
    a_rd_no_starve: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rd_req_valid && !rd_grant |=> rd_grant);
    a_wr_no_starve: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr_req_valid && !wr_grant |=> wr_grant);

endmodule

//--- rtl/perip_regs.sv
`include "perip_axi_cfg.svh"

module perip_regs (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  perip_axi_pkg::bus_req_t bus_req,
    input  logic                    bus_valid,
    output perip_axi_pkg::data_t    bus_rdata,
    input  logic [63:0]             virtual_sw_input,
    input  logic [7:0]              virtual_key_input,
    output logic [39:0]             virtual_seg_output,
    output logic [31:0]             virtual_led_output
);
    import perip_axi_pkg::*;

    localparam int WORD_W = `PERIP_ADDR_W - `PERIP_ADDR_LSB;
    localparam logic [WORD_W-1:0] IDX_SW_LO  = WORD_W'(`PERIP_IDX_SW_LO);
    localparam logic [WORD_W-1:0] IDX_SW_HI  = WORD_W'(`PERIP_IDX_SW_HI);
    localparam logic [WORD_W-1:0] IDX_KEY    = WORD_W'(`PERIP_IDX_KEY);
    localparam logic [WORD_W-1:0] IDX_SEG_LO = WORD_W'(`PERIP_IDX_SEG_LO);
    localparam logic [WORD_W-1:0] IDX_SEG_HI = WORD_W'(`PERIP_IDX_SEG_HI);
    localparam logic [WORD_W-1:0] IDX_LED    = WORD_W'(`PERIP_IDX_LED);

    logic [WORD_W-1:0] idx;
    data_t             seg_lo;
    logic [7:0]        seg_hi;
    data_t             led;
    data_t             rd_word;

    // byte lanes of new_w replace old_w where strb is set
    function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < `PERIP_DATA_W / 8; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign idx = bus_req.addr[`PERIP_ADDR_W-1:`PERIP_ADDR_LSB];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            seg_lo <= '0;
            seg_hi <= '0;
            led    <= '0;
        end else if (bus_valid && bus_req.write) begin
            case (idx)
                IDX_SEG_LO: seg_lo <= merge_bytes(seg_lo, bus_req.wdata, bus_req.strb);
                IDX_SEG_HI: begin
                    if (bus_req.strb[0])
                        seg_hi <= bus_req.wdata[7:0];   // upper lanes dropped
                end
                IDX_LED: led <= merge_bytes(led, bus_req.wdata, bus_req.strb);
                default: ;  // inputs and holes ignore writes
            endcase
        end
    end

    always_comb begin
        case (idx)
            IDX_SW_LO:  rd_word = virtual_sw_input[31:0];
            IDX_SW_HI:  rd_word = virtual_sw_input[63:32];
            IDX_KEY:    rd_word = {24'b0, virtual_key_input};
            IDX_SEG_LO: rd_word = seg_lo;
            IDX_SEG_HI: rd_word = {24'b0, seg_hi};
            IDX_LED:    rd_word = led;
            default:    rd_word = '0;
        endcase
    end

    // read word valid the cycle after the grant
    always_ff @(posedge S_AXI_ACLK) begin
        if (bus_valid && !bus_req.write)
            bus_rdata <= rd_word;
    end

    assign virtual_seg_output = {seg_hi, seg_lo};
    assign virtual_led_output = led;

endmodule

//--- sim.f
+incdir+rtl
rtl/perip_axi_pkg.sv
rtl/axi_burst_addr.sv
rtl/axi_read_engine.sv
rtl/axi_write_engine.sv
rtl/perip_bus_arbiter.sv
rtl/perip_regs.sv
rtl/perip_bridge_axi.sv
verification/tb_perip_bridge_axi.sv

//--- verification/tb_perip_bridge_axi.sv
`include "perip_axi_cfg.svh"

module tb_perip_bridge_axi;
    timeunit 1ns;
    timeprecision 100ps;
    import perip_axi_pkg::*;

    localparam int WAIT_LIMIT = 200;   // cycles per wait
    localparam int WAIT_AR = 0;
    localparam int WAIT_AW = 1;
    localparam int WAIT_W  = 2;
    localparam int WAIT_R  = 3;
    localparam int WAIT_B  = 4;

    logic        S_AXI_ACLK = 1'b0;
    logic        S_AXI_ARESETN;
    id_t         S_AXI_AWID;
    addr_t       S_AXI_AWADDR;
    len_t        S_AXI_AWLEN;
    logic [1:0]  S_AXI_AWBURST;
    logic        S_AXI_AWVALID;
    logic        S_AXI_AWREADY;
    data_t       S_AXI_WDATA;
    strb_t       S_AXI_WSTRB;
    logic        S_AXI_WLAST;
    logic        S_AXI_WVALID;
    logic        S_AXI_WREADY;
    id_t         S_AXI_BID;
    logic [1:0]  S_AXI_BRESP;
    logic        S_AXI_BVALID;
    logic        S_AXI_BREADY;
    id_t         S_AXI_ARID;
    addr_t       S_AXI_ARADDR;
    len_t        S_AXI_ARLEN;
    logic [1:0]  S_AXI_ARBURST;
    logic        S_AXI_ARVALID;
    logic        S_AXI_ARREADY;
    id_t         S_AXI_RID;
    data_t       S_AXI_RDATA;
    logic [1:0]  S_AXI_RRESP;
    logic        S_AXI_RLAST;
    logic        S_AXI_RVALID;
    logic        S_AXI_RREADY = 1'b0;
    logic [63:0] virtual_sw_input;
    logic [7:0]  virtual_key_input;
    logic [39:0] virtual_seg_output;
    logic [31:0] virtual_led_output;

    // reference copies of the writable registers
    data_t       m_seg_lo;
    logic [7:0]  m_seg_hi;
    data_t       m_led;

    // expected R beats and B ids, head moves on each handshake
    data_t       r_exp_data [0:63];
    logic        r_exp_last [0:63];
    id_t         r_exp_id   [0:63];
    logic [5:0]  r_head;
    logic [5:0]  r_tail;
    id_t         b_exp_id   [0:15];
    logic [3:0]  b_head;
    logic [3:0]  b_tail;
    logic [36:0] exp_r;         // data, last, id
    id_t         exp_bid;

    data_t       w_data_q[$];   // beats of the next write burst
    strb_t       w_strb_q[$];
    string       test_name;
    int          mismatches;
    int          failures;
    logic [31:0] rng = 32'h45b89f63;

    perip_bridge_axi i_dut (.*);

    always #50 S_AXI_ACLK = ~S_AXI_ACLK;

    assign exp_r   = {r_exp_data[r_head], r_exp_last[r_head], r_exp_id[r_head]};
    assign exp_bid = b_exp_id[b_head];

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // address of the following beat, from the AXI burst rules
    function automatic addr_t beat_addr_after(input addr_t a, input len_t len,
                                              input logic [1:0] burst);
        int unsigned word;
        int unsigned size;
        int unsigned base;
        int unsigned nxt;
        if (burst == BURST_FIXED)
            return a;
        word = 32'(a) & ~32'd3;
        nxt  = word + 4;
        if (burst == BURST_WRAP) begin
            size = (32'(len) + 1) * 4;   // window in bytes
            base = word - (word % size);
            if (nxt >= base + size)
                nxt = base;
        end
        return addr_t'(nxt);
    endfunction

    function automatic data_t strobe_merge(input data_t old_w, input data_t new_w,
                                           input strb_t s);
        data_t mask;
        for (int b = 0; b < 4; b++)
            mask[8*b +: 8] = {8{s[b]}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic data_t model_read(input addr_t a);
        int idx;
        idx = int'(a >> `PERIP_ADDR_LSB);
        case (idx)
            `PERIP_IDX_SW_LO:  return virtual_sw_input[31:0];
            `PERIP_IDX_SW_HI:  return virtual_sw_input[63:32];
            `PERIP_IDX_KEY:    return {24'h0, virtual_key_input};
            `PERIP_IDX_SEG_LO: return m_seg_lo;
            `PERIP_IDX_SEG_HI: return {24'h0, m_seg_hi};
            `PERIP_IDX_LED:    return m_led;
            default:           return '0;   // holes read as zero
        endcase
    endfunction

    task automatic model_write(input addr_t a, input data_t d, input strb_t s);
        int idx;
        idx = int'(a >> `PERIP_ADDR_LSB);
        if (idx == `PERIP_IDX_SEG_LO)
            m_seg_lo = strobe_merge(m_seg_lo, d, s);
        else if (idx == `PERIP_IDX_SEG_HI && s[0])
            m_seg_hi = d[7:0];   // only the low byte exists
        else if (idx == `PERIP_IDX_LED)
            m_led = strobe_merge(m_led, d, s);
    endtask

    function automatic logic condition_met(input int ch);
        case (ch)
            WAIT_AR: return S_AXI_ARREADY;
            WAIT_AW: return S_AXI_AWREADY;
            WAIT_W:  return S_AXI_WREADY;
            WAIT_R:  return r_head == r_tail;
            default: return b_head == b_tail;
        endcase
    endfunction

    task automatic step_cycle();
        @(posedge S_AXI_ACLK);
        #1;
    endtask

    // looks at falling edges, then moves past the rising edge that follows
    task automatic wait_for(input int ch, input string what);
        int n;
        n = 0;
        @(negedge S_AXI_ACLK);
        while (!condition_met(ch) && n < WAIT_LIMIT) begin
            @(negedge S_AXI_ACLK);
            n++;
        end
        if (!condition_met(ch)) begin
            $display("ERROR: %s timed out waiting for %s", test_name, what);
            failures++;
        end
        step_cycle();
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                              input logic [1:0] burst);
        addr_t a;
        a = addr;
        for (int i = 0; i <= int'(len); i++) begin
            r_exp_data[r_tail] = model_read(a);
            r_exp_last[r_tail] = (i == int'(len));
            r_exp_id[r_tail]   = id;
            r_tail = r_tail + 1'b1;
            a = beat_addr_after(a, len, burst);
        end
        S_AXI_ARID    = id;
        S_AXI_ARADDR  = addr;
        S_AXI_ARLEN   = len;
        S_AXI_ARBURST = burst;
        S_AXI_ARVALID = 1'b1;
        wait_for(WAIT_AR, "ARREADY");
        S_AXI_ARVALID = 1'b0;
    endtask

    // sends the beats queued in w_data_q and w_strb_q
    task automatic write_burst(input id_t id, input addr_t addr, input logic [1:0] burst);
        addr_t a;
        int    beats;
        len_t  len;
        a     = addr;
        beats = w_data_q.size();
        len   = len_t'(beats - 1);
        b_exp_id[b_tail] = id;
        b_tail = b_tail + 1'b1;
        S_AXI_AWID    = id;
        S_AXI_AWADDR  = addr;
        S_AXI_AWLEN   = len;
        S_AXI_AWBURST = burst;
        S_AXI_AWVALID = 1'b1;
        wait_for(WAIT_AW, "AWREADY");
        S_AXI_AWVALID = 1'b0;
        for (int i = 0; i < beats; i++) begin
            S_AXI_WDATA  = w_data_q.pop_front();
            S_AXI_WSTRB  = w_strb_q.pop_front();
            S_AXI_WLAST  = (i == beats - 1);
            S_AXI_WVALID = 1'b1;
            model_write(a, S_AXI_WDATA, S_AXI_WSTRB);
            wait_for(WAIT_W, "WREADY");
            a = beat_addr_after(a, len, burst);
        end
        S_AXI_WVALID = 1'b0;
        S_AXI_WLAST  = 1'b0;
    endtask

    task automatic check_output(input string what, input logic [39:0] exp_v,
                                input logic [39:0] act_v);
        assert (act_v == exp_v)
        else begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_v, act_v);
            mismatches++;
        end
    endtask

    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            r_head <= '0;
            b_head <= '0;
        end else begin
            if (S_AXI_RVALID && S_AXI_RREADY)
                r_head <= r_head + 1'b1;
            if (S_AXI_BVALID && S_AXI_BREADY)
                b_head <= b_head + 1'b1;
        end
    end

    always @(posedge S_AXI_ACLK) begin
        #1;
        rng = xorshift32(rng);
        S_AXI_RREADY = rng[0] | rng[1];   // ready about three cycles in four
    end

    // valid and ready flags in the order rvalid bvalid wready arready awready
    a_reset_state: assert property (@(posedge S_AXI_ACLK)
        $rose(S_AXI_ARESETN) |-> !S_AXI_RVALID && !S_AXI_BVALID && !S_AXI_WREADY
            && S_AXI_ARREADY && S_AXI_AWREADY
            && virtual_seg_output == '0 && virtual_led_output == '0)
        else begin
            $display("MISMATCH %s flags/seg/led expected %b/%h/%h actual %b/%h/%h",
                     test_name, 5'b00011, 40'h0, 32'h0,
                     $sampled({S_AXI_RVALID, S_AXI_BVALID, S_AXI_WREADY,
                               S_AXI_ARREADY, S_AXI_AWREADY}),
                     $sampled(virtual_seg_output), $sampled(virtual_led_output));
            mismatches++;
        end

    a_r_expected: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && S_AXI_RREADY |-> r_head != r_tail)
        else begin
            $display("ERROR: %s read beat arrived while none was expected", test_name);
            failures++;
        end

    a_r_beat: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && S_AXI_RREADY
            |-> {S_AXI_RDATA, S_AXI_RLAST, S_AXI_RID} == exp_r && S_AXI_RRESP == 2'b00)
        else begin
            $display("MISMATCH %s R data/last/id/resp expected %h/%b/%h/0 actual %h/%b/%h/%0d",
                     test_name, $sampled(exp_r[36:5]), $sampled(exp_r[4]),
                     $sampled(exp_r[3:0]), $sampled(S_AXI_RDATA), $sampled(S_AXI_RLAST),
                     $sampled(S_AXI_RID), $sampled(S_AXI_RRESP));
            mismatches++;
        end

    a_b_expected: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && S_AXI_BREADY |-> b_head != b_tail)
        else begin
            $display("ERROR: %s write response arrived while none was expected", test_name);
            failures++;
        end

    a_b_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && S_AXI_BREADY |-> S_AXI_BID == exp_bid && S_AXI_BRESP == 2'b00)
        else begin
            $display("MISMATCH %s B id/resp expected %h/0 actual %h/%0d", test_name,
                     $sampled(exp_bid), $sampled(S_AXI_BID), $sampled(S_AXI_BRESP));
            mismatches++;
        end

    initial begin
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWID    = '0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWLEN   = '0;
        S_AXI_AWBURST = BURST_INCR;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WLAST   = 1'b0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARID    = '0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARLEN   = '0;
        S_AXI_ARBURST = BURST_INCR;
        S_AXI_ARVALID = 1'b0;
        virtual_sw_input  = 64'hfedc_ba98_7654_3210;
        virtual_key_input = 8'h5a;
        m_seg_lo   = '0;
        m_seg_hi   = '0;
        m_led      = '0;
        r_tail     = '0;
        b_tail     = '0;
        mismatches = 0;
        failures   = 0;
        test_name  = "reset";
        repeat (3) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        S_AXI_BREADY  = 1'b1;
        step_cycle();

        test_name = "led_single_write";
        w_data_q.push_back(32'hc0de_1234);
        w_strb_q.push_back(4'hf);
        write_burst(4'd5, 16'h0018, BURST_INCR);
        wait_for(WAIT_B, "write response");
        check_output("led", 40'(m_led), 40'(virtual_led_output));

        test_name = "seg_strobe_write";
        w_data_q.push_back(32'h1122_3344);
        w_strb_q.push_back(4'hf);
        w_data_q.push_back(32'h5566_7788);
        w_strb_q.push_back(4'hf);
        write_burst(4'd2, 16'h0010, BURST_INCR);
        wait_for(WAIT_B, "write response");
        w_data_q.push_back(32'ha1b2_c3d4);
        w_strb_q.push_back(4'b0101);
        w_data_q.push_back(32'h9900_aabb);
        w_strb_q.push_back(4'b0011);
        write_burst(4'd3, 16'h0010, BURST_INCR);
        wait_for(WAIT_B, "write response");
        check_output("seg", {m_seg_hi, m_seg_lo}, virtual_seg_output);

        test_name = "incr_read";
        read_burst(4'd9, 16'h0000, 8'd3, BURST_INCR);
        wait_for(WAIT_R, "read data");

        test_name = "wrap_read";
        read_burst(4'd3, 16'h0018, 8'd3, BURST_WRAP);
        wait_for(WAIT_R, "read data");

        test_name = "fixed_read";
        read_burst(4'd12, 16'h0018, 8'd2, BURST_FIXED);
        wait_for(WAIT_R, "read data");

        test_name = "read_write_overlap";
        w_data_q.push_back(32'h0f0f_f0f0);
        w_strb_q.push_back(4'hf);
        w_data_q.push_back(32'hdead_beef);   // lands on an unmapped word
        w_strb_q.push_back(4'hf);
        fork
            read_burst(4'd1, 16'h0000, 8'd1, BURST_INCR);
            write_burst(4'd7, 16'h0018, BURST_INCR);
        join
        wait_for(WAIT_R, "read data");
        wait_for(WAIT_B, "write response");
        check_output("led", 40'(m_led), 40'(virtual_led_output));

        $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
